//--- Makefile
# Verilator flow for the issue buffer testbench

VERILATOR  ?= verilator
TOP        ?= issue_buffer_tb
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_MSG   ?= Test completed successfully

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the pass line shows up in the output
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
ib_pkg.sv
ib_inst_queue.sv
ib_dispatch_steer.sv
issue_buffer.sv
issue_buffer_asserts.sv
issue_buffer_tb.sv

//--- ib_dispatch_steer.sv
`timescale 1ns/100ps

module ib_dispatch_steer import ib_pkg::*; #(
    parameter int C_IN_NUM = 2
) (
    // Dispatch lanes, lane 0 oldest
    input  logic       [C_IN_NUM-1:0]               disp_valid_i,
    output logic       [C_IN_NUM-1:0]               disp_ready_o,
    input  ib_opcode_e [C_IN_NUM-1:0]               disp_opcode_i,
    input  logic       [C_IN_NUM-1:0][THREAD_W-1:0] disp_thread_i,
    input  logic       [C_IN_NUM-1:0][TAG_W-1:0]    disp_tag_i,
    // ALU queue push side
    output logic       [C_IN_NUM-1:0]               alu_push_valid_o,
    input  logic       [C_IN_NUM-1:0]               alu_push_ready_i,
    output ib_opcode_e [C_IN_NUM-1:0]               alu_push_opcode_o,
    output logic       [C_IN_NUM-1:0][THREAD_W-1:0] alu_push_thread_o,
    output logic       [C_IN_NUM-1:0][TAG_W-1:0]    alu_push_tag_o,
    // Load queue push side
    output logic       [C_IN_NUM-1:0]               ld_push_valid_o,
    input  logic       [C_IN_NUM-1:0]               ld_push_ready_i,
    output ib_opcode_e [C_IN_NUM-1:0]               ld_push_opcode_o,
    output logic       [C_IN_NUM-1:0][THREAD_W-1:0] ld_push_thread_o,
    output logic       [C_IN_NUM-1:0][TAG_W-1:0]    ld_push_tag_o
);

    localparam int C_CNT_W = (C_IN_NUM > 1) ? $clog2(C_IN_NUM) : 1;

    // Running count of older valid lanes per class
    logic [C_CNT_W-1:0] alu_cnt;
    logic [C_CNT_W-1:0] ld_cnt;
    logic [C_IN_NUM-1:0] lane_is_ld;
    logic [C_IN_NUM-1:0][C_CNT_W-1:0] slot;
    // Low once an older valid lane stalls
    logic older_ok;

    always_comb begin
        alu_cnt          = '0;
        ld_cnt           = '0;
        older_ok         = 1'b1;
        alu_push_valid_o = '0;
        ld_push_valid_o  = '0;
        alu_push_thread_o = '0;
        alu_push_tag_o   = '0;
        ld_push_thread_o = '0;
        ld_push_tag_o    = '0;
        for (int k = 0; k < C_IN_NUM; k++) begin
            alu_push_opcode_o[k] = OP_ADD;
            ld_push_opcode_o[k]  = OP_LW;
        end

        for (int k = 0; k < C_IN_NUM; k++) begin
            // Compacted slot in the lane's class queue
            lane_is_ld[k] = is_load(disp_opcode_i[k]);
            slot[k]       = lane_is_ld[k] ? ld_cnt : alu_cnt;
            if (lane_is_ld[k]) begin
                disp_ready_o[k] = older_ok && ld_push_ready_i[slot[k]];
            end else begin
                disp_ready_o[k] = older_ok && alu_push_ready_i[slot[k]];
            end

            if (disp_valid_i[k]) begin
                if (!disp_ready_o[k]) begin
                    older_ok = 1'b0;
                end else if (lane_is_ld[k]) begin
                    ld_push_valid_o[slot[k]]   = 1'b1;
                    ld_push_opcode_o[slot[k]]  = disp_opcode_i[k];
                    ld_push_thread_o[slot[k]]  = disp_thread_i[k];
                    ld_push_tag_o[slot[k]]     = disp_tag_i[k];
                end else begin
                    alu_push_valid_o[slot[k]]  = 1'b1;
                    alu_push_opcode_o[slot[k]] = disp_opcode_i[k];
                    alu_push_thread_o[slot[k]] = disp_thread_i[k];
                    alu_push_tag_o[slot[k]]    = disp_tag_i[k];
                end
                // Younger lanes of this class shift one slot up
                if (lane_is_ld[k]) begin
                    ld_cnt = ld_cnt + 1'b1;
                end else begin
                    alu_cnt = alu_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- ib_inst_queue.sv
`timescale 1ns/100ps

module ib_inst_queue import ib_pkg::*; #(
    parameter int C_SIZE    = 8,
    parameter int C_IN_NUM  = 2,
    parameter int C_OUT_NUM = 2
) (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    // Push side, one lane per dispatch slot
    input  logic       [C_IN_NUM-1:0]            s_valid_i,
    output logic       [C_IN_NUM-1:0]            s_ready_o,
    input  ib_opcode_e [C_IN_NUM-1:0]            s_opcode_i,
    input  logic       [C_IN_NUM-1:0][THREAD_W-1:0] s_thread_i,
    input  logic       [C_IN_NUM-1:0][TAG_W-1:0] s_tag_i,
    // Pop side, port 0 is the head
    output logic       [C_OUT_NUM-1:0]           m_valid_o,
    input  logic       [C_OUT_NUM-1:0]           m_ready_i,
    output ib_opcode_e [C_OUT_NUM-1:0]           m_opcode_o,
    output logic       [C_OUT_NUM-1:0][THREAD_W-1:0] m_thread_o,
    output logic       [C_OUT_NUM-1:0][TAG_W-1:0] m_tag_o,
    // Flush controls
    input  logic       [THREAD_NUM-1:0]          br_mis_i,
    input  logic                                 exception_i
);

    localparam int C_IDX_W = (C_SIZE > 1) ? $clog2(C_SIZE) : 1;
    localparam int C_NUM_W = $clog2(C_SIZE + 1);

    // Pointers, rollover bit tells full from empty
    logic [C_IDX_W-1:0] head;
    logic [C_IDX_W-1:0] tail;
    logic               head_roll;
    logic               tail_roll;
    logic [C_IDX_W-1:0] next_head;
    logic [C_IDX_W-1:0] next_tail;
    logic               head_wrap;
    logic               tail_wrap;

    // Entry storage
    logic [C_SIZE-1:0]  valid_q;
    ib_opcode_e         opcode_q [C_SIZE];
    logic [THREAD_W-1:0] thread_q [C_SIZE];
    logic [TAG_W-1:0]   tag_q    [C_SIZE];

    // Occupancy
    logic [C_NUM_W-1:0] data_num;
    logic [C_NUM_W-1:0] free_num;
    logic [C_NUM_W-1:0] push_num;
    logic [C_NUM_W-1:0] pop_num;

    // Per-lane and per-port control
    logic [C_IN_NUM-1:0]               push_en;
    logic [C_IN_NUM-1:0][C_IDX_W-1:0]  push_idx;
    logic [C_OUT_NUM-1:0][C_IDX_W-1:0] pop_idx;
    logic [C_OUT_NUM-1:0]              in_range;
    logic [C_OUT_NUM-1:0]              squash;
    logic [C_OUT_NUM-1:0]              leave;
    logic [C_SIZE-1:0]                 push_sel;
    logic [C_SIZE-1:0]                 leave_sel;

    // ------------------------------------------------------------------------
    // Occupancy and push ready
    // ------------------------------------------------------------------------

    always_comb begin
        if (head_roll == tail_roll) begin
            data_num = C_NUM_W'(int'(tail) - int'(head));
        end else begin
            data_num = C_NUM_W'(C_SIZE - int'(head) + int'(tail));
        end
        // Slots freed by this cycle's pops count as free
        free_num = C_NUM_W'(C_SIZE - int'(data_num) + int'(pop_num));
    end

    always_comb begin
        push_num = '0;
        push_sel = '0;
        for (int j = 0; j < C_IN_NUM; j++) begin
            s_ready_o[j] = (j < int'(free_num));
            push_en[j]   = s_valid_i[j] && s_ready_o[j];
            // Lane j lands j slots past the tail
            if (int'(tail) + j >= C_SIZE) begin
                push_idx[j] = C_IDX_W'(int'(tail) + j - C_SIZE);
            end else begin
                push_idx[j] = C_IDX_W'(int'(tail) + j);
            end
            if (push_en[j]) begin
                push_num              = push_num + 1'b1;
                push_sel[push_idx[j]] = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Pop ports and head squash
    // ------------------------------------------------------------------------

    always_comb begin
        pop_num   = '0;
        leave_sel = '0;
        for (int k = 0; k < C_OUT_NUM; k++) begin
            if (int'(head) + k >= C_SIZE) begin
                pop_idx[k] = C_IDX_W'(int'(head) + k - C_SIZE);
            end else begin
                pop_idx[k] = C_IDX_W'(int'(head) + k);
            end
            m_opcode_o[k] = opcode_q[pop_idx[k]];
            m_thread_o[k] = thread_q[pop_idx[k]];
            m_tag_o[k]    = tag_q[pop_idx[k]];

            // Live entry unless cleared or hit by this cycle's mispredict
            in_range[k]  = (k < int'(data_num));
            m_valid_o[k] = in_range[k] && valid_q[pop_idx[k]]
                           && !br_mis_i[thread_q[pop_idx[k]]];
            squash[k]    = in_range[k] && !m_valid_o[k];

            // Leaves on accept or squash, only behind a leaving port
            leave[k] = (m_valid_o[k] && m_ready_i[k]) || squash[k];
            if (k > 0) begin
                leave[k] = leave[k] && leave[k-1];
            end
            if (leave[k]) begin
                pop_num              = pop_num + 1'b1;
                leave_sel[pop_idx[k]] = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Pointer update
    // ------------------------------------------------------------------------

    always_comb begin
        head_wrap = (int'(head) + int'(pop_num) >= C_SIZE);
        tail_wrap = (int'(tail) + int'(push_num) >= C_SIZE);
        if (head_wrap) begin
            next_head = C_IDX_W'(int'(head) + int'(pop_num) - C_SIZE);
        end else begin
            next_head = C_IDX_W'(int'(head) + int'(pop_num));
        end
        if (tail_wrap) begin
            next_tail = C_IDX_W'(int'(tail) + int'(push_num) - C_SIZE);
        end else begin
            next_tail = C_IDX_W'(int'(tail) + int'(push_num));
        end
    end

    always_ff @(posedge clk_i) begin
        // Exception empties the queue like reset
        if (rst_i || exception_i) begin
            head      <= '0;
            tail      <= '0;
            head_roll <= 1'b0;
            tail_roll <= 1'b0;
        end else begin
            head      <= next_head;
            tail      <= next_tail;
            head_roll <= head_roll ^ head_wrap;
            tail_roll <= tail_roll ^ tail_wrap;
        end
    end

    // ------------------------------------------------------------------------
    // Entry valid bits and payload
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (rst_i || exception_i) begin
            valid_q <= '0;
        end else begin
            for (int e = 0; e < C_SIZE; e++) begin
                // Push wins over a pop of the same slot
                if (push_sel[e]) begin
                    valid_q[e] <= 1'b1;
                end else if (leave_sel[e]) begin
                    valid_q[e] <= 1'b0;
                end else if (valid_q[e] && br_mis_i[thread_q[e]]) begin
                    // Squashed in place, drained later from the head
                    valid_q[e] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int j = 0; j < C_IN_NUM; j++) begin
            if (push_en[j]) begin
                opcode_q[push_idx[j]] <= s_opcode_i[j];
                thread_q[push_idx[j]] <= s_thread_i[j];
                tag_q[push_idx[j]]    <= s_tag_i[j];
            end
        end
    end

endmodule

//--- ib_pkg.sv
package ib_pkg;

    // ------------------------------------------------------------------------
    // Core-wide widths
    // ------------------------------------------------------------------------

    // Hardware threads, also the width of the misprediction vector
    localparam int THREAD_NUM = 2;
    // Thread index width
    localparam int THREAD_W = 1;
    // Destination tag width
    localparam int TAG_W = 6;

    // ------------------------------------------------------------------------
    // Opcodes
    // ------------------------------------------------------------------------

    // ALU class first, loads in the top three codes
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_SLT = 3'd4,
        OP_LW  = 3'd5,
        OP_LH  = 3'd6,
        OP_LB  = 3'd7
    } ib_opcode_e;

    // Class decode, high for the load class
    function automatic logic is_load(ib_opcode_e op);
        return (op == OP_LW) || (op == OP_LH) || (op == OP_LB);
    endfunction

endpackage

//--- issue_buffer.sv
`timescale 1ns/100ps

module issue_buffer import ib_pkg::*; #(
    parameter int IN_NUM       = 2,
    parameter int ALU_Q_SIZE   = 8,
    parameter int LOAD_Q_SIZE  = 4,
    parameter int ALU_OUT_NUM  = 2,
    parameter int LOAD_OUT_NUM = 1
) (
    input  logic                                    clk_i,
    input  logic                                    rst_i,
    // Dispatch lanes
    input  logic       [IN_NUM-1:0]                 disp_valid_i,
    output logic       [IN_NUM-1:0]                 disp_ready_o,
    input  ib_opcode_e [IN_NUM-1:0]                 disp_opcode_i,
    input  logic       [IN_NUM-1:0][THREAD_W-1:0]   disp_thread_i,
    input  logic       [IN_NUM-1:0][TAG_W-1:0]      disp_tag_i,
    // ALU issue ports
    output logic       [ALU_OUT_NUM-1:0]            alu_valid_o,
    input  logic       [ALU_OUT_NUM-1:0]            alu_ready_i,
    output ib_opcode_e [ALU_OUT_NUM-1:0]            alu_opcode_o,
    output logic       [ALU_OUT_NUM-1:0][THREAD_W-1:0] alu_thread_o,
    output logic       [ALU_OUT_NUM-1:0][TAG_W-1:0] alu_tag_o,
    // Load issue ports
    output logic       [LOAD_OUT_NUM-1:0]           ld_valid_o,
    input  logic       [LOAD_OUT_NUM-1:0]           ld_ready_i,
    output ib_opcode_e [LOAD_OUT_NUM-1:0]           ld_opcode_o,
    output logic       [LOAD_OUT_NUM-1:0][THREAD_W-1:0] ld_thread_o,
    output logic       [LOAD_OUT_NUM-1:0][TAG_W-1:0] ld_tag_o,
    // Flush
    input  logic       [THREAD_NUM-1:0]             br_mis_i,
    input  logic                                    exception_i
);

    // ------------------------------------------------------------------------
    // Steering to queue push lanes
    // ------------------------------------------------------------------------

    logic       [IN_NUM-1:0]               alu_push_valid;
    logic       [IN_NUM-1:0]               alu_push_ready;
    ib_opcode_e [IN_NUM-1:0]               alu_push_opcode;
    logic       [IN_NUM-1:0][THREAD_W-1:0] alu_push_thread;
    logic       [IN_NUM-1:0][TAG_W-1:0]    alu_push_tag;
    logic       [IN_NUM-1:0]               ld_push_valid;
    logic       [IN_NUM-1:0]               ld_push_ready;
    ib_opcode_e [IN_NUM-1:0]               ld_push_opcode;
    logic       [IN_NUM-1:0][THREAD_W-1:0] ld_push_thread;
    logic       [IN_NUM-1:0][TAG_W-1:0]    ld_push_tag;

    ib_dispatch_steer #(
        .C_IN_NUM (IN_NUM)
    ) i_steer (
        .disp_valid_i      (disp_valid_i),
        .disp_ready_o      (disp_ready_o),
        .disp_opcode_i     (disp_opcode_i),
        .disp_thread_i     (disp_thread_i),
        .disp_tag_i        (disp_tag_i),
        .alu_push_valid_o  (alu_push_valid),
        .alu_push_ready_i  (alu_push_ready),
        .alu_push_opcode_o (alu_push_opcode),
        .alu_push_thread_o (alu_push_thread),
        .alu_push_tag_o    (alu_push_tag),
        .ld_push_valid_o   (ld_push_valid),
        .ld_push_ready_i   (ld_push_ready),
        .ld_push_opcode_o  (ld_push_opcode),
        .ld_push_thread_o  (ld_push_thread),
        .ld_push_tag_o     (ld_push_tag)
    );

    // ------------------------------------------------------------------------
    // Class queues
    // ------------------------------------------------------------------------

    // Arithmetic, two issue ports
    ib_inst_queue #(
        .C_SIZE    (ALU_Q_SIZE),
        .C_IN_NUM  (IN_NUM),
        .C_OUT_NUM (ALU_OUT_NUM)
    ) i_alu_q (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .s_valid_i   (alu_push_valid),
        .s_ready_o   (alu_push_ready),
        .s_opcode_i  (alu_push_opcode),
        .s_thread_i  (alu_push_thread),
        .s_tag_i     (alu_push_tag),
        .m_valid_o   (alu_valid_o),
        .m_ready_i   (alu_ready_i),
        .m_opcode_o  (alu_opcode_o),
        .m_thread_o  (alu_thread_o),
        .m_tag_o     (alu_tag_o),
        .br_mis_i    (br_mis_i),
        .exception_i (exception_i)
    );

    // Loads, single issue port
    ib_inst_queue #(
        .C_SIZE    (LOAD_Q_SIZE),
        .C_IN_NUM  (IN_NUM),
        .C_OUT_NUM (LOAD_OUT_NUM)
    ) i_ld_q (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .s_valid_i   (ld_push_valid),
        .s_ready_o   (ld_push_ready),
        .s_opcode_i  (ld_push_opcode),
        .s_thread_i  (ld_push_thread),
        .s_tag_i     (ld_push_tag),
        .m_valid_o   (ld_valid_o),
        .m_ready_i   (ld_ready_i),
        .m_opcode_o  (ld_opcode_o),
        .m_thread_o  (ld_thread_o),
        .m_tag_o     (ld_tag_o),
        .br_mis_i    (br_mis_i),
        .exception_i (exception_i)
    );

endmodule

//--- issue_buffer_asserts.sv
`timescale 1ns/100ps

module issue_buffer_asserts #(
    parameter int IN_NUM       = 2,
    parameter int ALU_OUT_NUM  = 2,
    parameter int LOAD_OUT_NUM = 1
) (
    input logic                    clk_i,
    input logic                    rst_i,
    input logic [IN_NUM-1:0]       disp_valid_i,
    input logic [IN_NUM-1:0]       disp_ready_o,
    input logic [ALU_OUT_NUM-1:0]  alu_valid_o,
    input logic [ALU_OUT_NUM-1:0]  alu_ready_i,
    input logic [LOAD_OUT_NUM-1:0] ld_valid_o,
    input logic [LOAD_OUT_NUM-1:0] ld_ready_i,
    input logic                    exception_i
);

    genvar k;

    // Consumer ready must be a prefix of the ports
    for (k = 1; k < ALU_OUT_NUM; k++) begin : g_alu_prefix
        assert property (@(posedge clk_i) disable iff (rst_i)
            alu_ready_i[k] |-> alu_ready_i[k-1])
            else $error("ALU ready on port %0d without port %0d", k, k - 1);
    end

    for (k = 1; k < LOAD_OUT_NUM; k++) begin : g_ld_prefix
        assert property (@(posedge clk_i) disable iff (rst_i)
            ld_ready_i[k] |-> ld_ready_i[k-1])
            else $error("Load ready on port %0d without port %0d", k, k - 1);
    end

    // Both queues empty right after an exception
    assert property (@(posedge clk_i) disable iff (rst_i)
        exception_i |=> ((alu_valid_o == '0) && (ld_valid_o == '0)))
        else $error("Pop valid high in the cycle after an exception");

    // No lane transfers past a stalled older lane
    for (k = 1; k < IN_NUM; k++) begin : g_in_order
        assert property (@(posedge clk_i) disable iff (rst_i)
            (disp_valid_i[k] && disp_ready_o[k])
                |-> ((disp_valid_i[k-1:0] & ~disp_ready_o[k-1:0]) == '0))
            else $error("Lane %0d accepted while an older lane stalls", k);
    end

endmodule

bind issue_buffer issue_buffer_asserts #(
    .IN_NUM       (IN_NUM),
    .ALU_OUT_NUM  (ALU_OUT_NUM),
    .LOAD_OUT_NUM (LOAD_OUT_NUM)
) i_asserts (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .disp_valid_i (disp_valid_i),
    .disp_ready_o (disp_ready_o),
    .alu_valid_o  (alu_valid_o),
    .alu_ready_i  (alu_ready_i),
    .ld_valid_o   (ld_valid_o),
    .ld_ready_i   (ld_ready_i),
    .exception_i  (exception_i)
);

//--- issue_buffer_tb.sv
`timescale 1ns/100ps

module issue_buffer_tb import ib_pkg::*; ();

    localparam int IN_NUM       = 2;
    localparam int ALU_Q_SIZE   = 8;
    localparam int LOAD_Q_SIZE  = 4;
    localparam int ALU_OUT_NUM  = 2;
    localparam int LOAD_OUT_NUM = 1;
    // Class index, 0 for ALU and 1 for loads
    localparam int NQ           = 2;
    localparam int STIM_CYCLES  = 2000;
    // Twice the stimulus length
    localparam int MAX_CYCLES   = 2 * STIM_CYCLES;

    logic                                    clk_i;
    logic                                    rst_i;
    logic       [IN_NUM-1:0]                 disp_valid_i;
    logic       [IN_NUM-1:0]                 disp_ready_o;
    ib_opcode_e [IN_NUM-1:0]                 disp_opcode_i;
    logic       [IN_NUM-1:0][THREAD_W-1:0]   disp_thread_i;
    logic       [IN_NUM-1:0][TAG_W-1:0]      disp_tag_i;
    logic       [ALU_OUT_NUM-1:0]            alu_valid_o;
    logic       [ALU_OUT_NUM-1:0]            alu_ready_i;
    ib_opcode_e [ALU_OUT_NUM-1:0]            alu_opcode_o;
    logic       [ALU_OUT_NUM-1:0][THREAD_W-1:0] alu_thread_o;
    logic       [ALU_OUT_NUM-1:0][TAG_W-1:0] alu_tag_o;
    logic       [LOAD_OUT_NUM-1:0]           ld_valid_o;
    logic       [LOAD_OUT_NUM-1:0]           ld_ready_i;
    ib_opcode_e [LOAD_OUT_NUM-1:0]           ld_opcode_o;
    logic       [LOAD_OUT_NUM-1:0][THREAD_W-1:0] ld_thread_o;
    logic       [LOAD_OUT_NUM-1:0][TAG_W-1:0] ld_tag_o;
    logic       [THREAD_NUM-1:0]             br_mis_i;
    logic                                    exception_i;

    // Reference model, one age-ordered list per class, index 0 oldest
    ib_opcode_e          m_op  [NQ][ALU_Q_SIZE];
    logic [THREAD_W-1:0] m_thr [NQ][ALU_Q_SIZE];
    logic [TAG_W-1:0]    m_tag [NQ][ALU_Q_SIZE];
    logic                m_vld [NQ][ALU_Q_SIZE];
    int                  m_cnt [NQ];
    // Results of the last check, applied at the next edge
    int                  pop_cnt [NQ];
    logic [IN_NUM-1:0]   exp_ready;

    int   seed;
    int   cyc;
    int   stim_cnt;
    int   errors;
    int   checks;
    logic stim_done;

    issue_buffer #(
        .IN_NUM       (IN_NUM),
        .ALU_Q_SIZE   (ALU_Q_SIZE),
        .LOAD_Q_SIZE  (LOAD_Q_SIZE),
        .ALU_OUT_NUM  (ALU_OUT_NUM),
        .LOAD_OUT_NUM (LOAD_OUT_NUM)
    ) i_dut (.*);

    // 20 ns period
    always #10 clk_i = ~clk_i;

    function automatic int q_size(int q);
        return (q == 0) ? ALU_Q_SIZE : LOAD_Q_SIZE;
    endfunction

    function automatic int q_ports(int q);
        return (q == 0) ? ALU_OUT_NUM : LOAD_OUT_NUM;
    endfunction

    // Loads go to class 1, arithmetic to class 0
    function automatic int class_of(ib_opcode_e op);
        case (op)
            OP_LW, OP_LH, OP_LB: return 1;
            default:             return 0;
        endcase
    endfunction

    task automatic report_mismatch(string name, int exp, int act);
        $display("ERR %0t %s exp=%0h act=%0h", $time, name, exp, act);
        errors++;
    endtask

    // ------------------------------------------------------------------------
    // Expected outputs, compared between edges
    // ------------------------------------------------------------------------

    task automatic check_outputs();
        int                  free_cnt [NQ];
        int                  slot [NQ];
        int                  c;
        logic                older_ok;
        logic                leave;
        logic                live;
        logic                rdy;
        logic                act_vld;
        ib_opcode_e          act_op;
        logic [THREAD_W-1:0] act_thr;
        logic [TAG_W-1:0]    act_tag;
        string               pfx;
        checks++;
        for (int q = 0; q < NQ; q++) begin
            pop_cnt[q] = 0;
            leave      = 1'b1;
            if (q == 0) begin
                pfx = "alu";
            end else begin
                pfx = "ld";
            end
            for (int k = 0; k < q_ports(q); k++) begin
                act_vld = (q == 0) ? alu_valid_o[k]  : ld_valid_o[0];
                act_op  = (q == 0) ? alu_opcode_o[k] : ld_opcode_o[0];
                act_thr = (q == 0) ? alu_thread_o[k] : ld_thread_o[0];
                act_tag = (q == 0) ? alu_tag_o[k]    : ld_tag_o[0];
                rdy     = (q == 0) ? alu_ready_i[k]  : ld_ready_i[0];
                // Stored, not cleared, thread not hit this cycle
                live = (k < m_cnt[q]) && m_vld[q][k] && !br_mis_i[m_thr[q][k]];
                if (live !== act_vld) begin
                    report_mismatch($sformatf("%s_valid_o[%0d]", pfx, k), live, act_vld);
                end
                if (live && (act_op !== m_op[q][k])) begin
                    report_mismatch($sformatf("%s_opcode_o[%0d]", pfx, k), m_op[q][k], act_op);
                end
                if (live && (act_thr !== m_thr[q][k])) begin
                    report_mismatch($sformatf("%s_thread_o[%0d]", pfx, k), m_thr[q][k], act_thr);
                end
                if (live && (act_tag !== m_tag[q][k])) begin
                    report_mismatch($sformatf("%s_tag_o[%0d]", pfx, k), m_tag[q][k], act_tag);
                end
                // Accepted or squashed, and only behind a leaving port
                leave = leave && (k < m_cnt[q]) && (!live || rdy);
                if (leave) begin
                    pop_cnt[q]++;
                end
            end
            // Slots emptied this cycle count as free
            free_cnt[q] = q_size(q) - m_cnt[q] + pop_cnt[q];
        end

        // In-order dispatch, a stalled lane blocks all younger lanes
        older_ok = 1'b1;
        slot[0]  = 0;
        slot[1]  = 0;
        for (int j = 0; j < IN_NUM; j++) begin
            c            = class_of(disp_opcode_i[j]);
            exp_ready[j] = older_ok && (slot[c] < free_cnt[c]);
            if (disp_valid_i[j] && exp_ready[j]) begin
                slot[c]++;
            end else if (disp_valid_i[j]) begin
                older_ok = 1'b0;
            end
        end
        if (exp_ready !== disp_ready_o) begin
            report_mismatch("disp_ready_o", exp_ready, disp_ready_o);
        end
    endtask

    // ------------------------------------------------------------------------
    // Model update at the edge
    // ------------------------------------------------------------------------

    task automatic update_model();
        int c;
        if (rst_i || exception_i) begin
            m_cnt[0] = 0;
            m_cnt[1] = 0;
        end else begin
            for (int q = 0; q < NQ; q++) begin
                // Drop the leaving head entries
                for (int e = 0; e + pop_cnt[q] < m_cnt[q]; e++) begin
                    m_op[q][e]  = m_op[q][e + pop_cnt[q]];
                    m_thr[q][e] = m_thr[q][e + pop_cnt[q]];
                    m_tag[q][e] = m_tag[q][e + pop_cnt[q]];
                    m_vld[q][e] = m_vld[q][e + pop_cnt[q]];
                end
                m_cnt[q] = m_cnt[q] - pop_cnt[q];
                // Mispredicted thread cleared in place
                for (int e = 0; e < m_cnt[q]; e++) begin
                    if (br_mis_i[m_thr[q][e]]) begin
                        m_vld[q][e] = 1'b0;
                    end
                end
            end
            // Entries pushed this cycle survive the squash
            for (int j = 0; j < IN_NUM; j++) begin
                if (disp_valid_i[j] && exp_ready[j]) begin
                    c               = class_of(disp_opcode_i[j]);
                    m_op[c][m_cnt[c]]  = disp_opcode_i[j];
                    m_thr[c][m_cnt[c]] = disp_thread_i[j];
                    m_tag[c][m_cnt[c]] = disp_tag_i[j];
                    m_vld[c][m_cnt[c]] = 1'b1;
                    m_cnt[c]++;
                end
            end
        end
    endtask

    task automatic drive_stimulus();
        logic [31:0] r;
        for (int j = 0; j < IN_NUM; j++) begin
            r = $random(seed);
            // Lane busy three cycles in four
            disp_valid_i[j]  <= r[0] | r[1];
            disp_opcode_i[j] <= ib_opcode_e'(r[4:2]);
            disp_thread_i[j] <= r[5 +: THREAD_W];
            disp_tag_i[j]    <= r[6 +: TAG_W];
        end
        r = $random(seed);
        // Stall phase lets both queues fill up
        if ((stim_cnt % 200) < 40) begin
            alu_ready_i <= '0;
            ld_ready_i  <= '0;
        end else begin
            alu_ready_i <= (r[13:12] == 2'd0) ? 2'b00 : ((r[13:12] == 2'd1) ? 2'b01 : 2'b11);
            ld_ready_i  <= r[14] | r[15];
        end
        br_mis_i[0] <= (r[20:16] == 5'd0);
        br_mis_i[1] <= (r[25:21] == 5'd0);
        exception_i <= (r[31:26] == 6'd0);
    endtask

    always @(negedge clk_i) begin
        if (!rst_i) begin
            check_outputs();
        end
    end

    always @(posedge clk_i) begin
        update_model();
        // High through the first five edges
        rst_i <= (cyc < 4);
        if (cyc >= 4 && stim_cnt < STIM_CYCLES) begin
            drive_stimulus();
            stim_cnt++;
        end else if (stim_cnt >= STIM_CYCLES) begin
            disp_valid_i <= '0;
            br_mis_i     <= '0;
            exception_i  <= 1'b0;
            stim_done    <= 1'b1;
        end
        cyc++;
        if (cyc >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            errors++;
            $display("Cycles checked: %0d  Errors: %0d", checks, errors);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        seed          = 27;
        cyc           = 0;
        stim_cnt      = 0;
        errors        = 0;
        checks        = 0;
        stim_done     = 1'b0;
        m_cnt[0]      = 0;
        m_cnt[1]      = 0;
        pop_cnt[0]    = 0;
        pop_cnt[1]    = 0;
        exp_ready     = '0;
        clk_i         = 1'b0;
        rst_i         = 1'b1;
        disp_valid_i  = '0;
        disp_opcode_i = '{default: OP_ADD};
        disp_thread_i = '0;
        disp_tag_i    = '0;
        alu_ready_i   = '0;
        ld_ready_i    = '0;
        br_mis_i      = '0;
        exception_i   = 1'b0;
        wait (stim_done);
        repeat (2) @(posedge clk_i);
        $display("Cycles checked: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
